//--- common/cpu8_pkg.sv
// encodings are the 8-bit ones of the reference ALU; widths cannot be changed without a new encoding
package cpu8_pkg;

	// data path and address width
	localparam int byte_w = 8;
	localparam int addr_w = 8;

	// program and data memory sizes in bytes
	localparam int rom_depth = 256;
	localparam int ram_depth = 256;

	// register, memory byte or immediate
	typedef logic [byte_w-1:0] byte_t;
	// program or data address
	typedef logic [addr_w-1:0] addr_t;
	// alu result with carry out in the top bit
	typedef logic [byte_w:0] alu_result_t;

	// alu operations in encoding order
	typedef enum logic [3:0] {
		op_zero   = 4'h0,
		op_load_a = 4'h1,
		op_inc    = 4'h2,
		op_dec    = 4'h3,
		op_asl    = 4'h4,
		op_lsr    = 4'h5,
		op_rol    = 4'h6,
		op_ror    = 4'h7,
		op_or     = 4'h8,
		op_and    = 4'h9,
		op_xor    = 4'ha,
		op_load_b = 4'hb,
		op_add    = 4'hc,
		op_sub    = 4'hd,
		op_adc    = 4'he,
		op_sbb    = 4'hf
	} alu_op_e;

	// where a compute result goes
	typedef enum logic [1:0] {
		dest_a   = 2'b00,
		dest_b   = 2'b01,
		dest_ip  = 2'b10,
		dest_nop = 2'b11
	} dest_e;

	// top two opcode bits pick the instruction class
	localparam logic [1:0] cls_reg  = 2'b00;
	localparam logic [1:0] cls_imm  = 2'b01;
	localparam logic [1:0] cls_misc = 2'b10;
	localparam logic [1:0] cls_mem  = 2'b11;

	// misc class prefixes in the top nibble
	localparam logic [3:0] pfx_store  = 4'b1001;
	localparam logic [3:0] pfx_branch = 4'b1010;

	// fully decoded misc opcodes
	localparam byte_t insn_swap_ab     = 8'b1000_0001;
	localparam byte_t insn_clear_carry = 8'b1000_1000;
	localparam byte_t insn_reset       = 8'b1011_1111;

	// branch test field bit positions
	localparam int brn_zv = 3;
	localparam int brn_zu = 2;
	localparam int brn_cv = 1;
	localparam int brn_cu = 0;

	// one fetched instruction on its way to execute
	typedef struct packed {
		logic  valid;
		addr_t ip;
		byte_t opcode;
		byte_t operand;
	} fetch_bundle_t;

endpackage

//--- alu/cpu8_alu.sv
// purely combinational; carry in only matters for rotates and adc/sbb and bit 8 is carry or borrow out
`timescale 1ns/1ps

module cpu8_alu (
	input  cpu8_pkg::byte_t       a,
	input  cpu8_pkg::byte_t       b,
	input  logic                  carry,
	input  cpu8_pkg::alu_op_e     op,
	output cpu8_pkg::alu_result_t y
);
	import cpu8_pkg::*;

	// zero extended operands so sums keep their carry
	alu_result_t a_ext;
	alu_result_t b_ext;
	alu_result_t c_ext;

	assign a_ext = {1'b0, a};
	assign b_ext = {1'b0, b};
	assign c_ext = {{byte_w{1'b0}}, carry};

	always_comb begin
		unique case (op)
			// unary group
			op_zero:   y = '0;
			op_load_a: y = a_ext;
			op_inc:    y = a_ext + alu_result_t'(1);
			// borrow lands in bit 8 when a is zero
			op_dec:    y = a_ext - alu_result_t'(1);
			// shifted out bit goes to bit 8
			op_asl:    y = {a, 1'b0};
			op_lsr:    y = {a[0], 1'b0, a[byte_w-1:1]};
			// rotates pass through carry
			op_rol:    y = {a, carry};
			op_ror:    y = {a[0], carry, a[byte_w-1:1]};
			// logical group clears carry
			op_or:     y = {1'b0, a | b};
			op_and:    y = {1'b0, a & b};
			op_xor:    y = {1'b0, a ^ b};
			op_load_b: y = b_ext;
			// arithmetic group
			op_add:    y = a_ext + b_ext;
			op_sub:    y = a_ext - b_ext;
			op_adc:    y = a_ext + b_ext + c_ext;
			op_sbb:    y = a_ext - b_ext - c_ext;
			default:   y = '0;
		endcase
	end

endmodule

//--- design/cpu8_fetch.sv
// program memory is written only while reset is high; no back-pressure, one bundle every cycle
`timescale 1ns/1ps

module cpu8_fetch (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    prog_we,
	input  cpu8_pkg::addr_t         prog_addr,
	input  cpu8_pkg::byte_t         prog_data,
	input  logic                    redirect,
	input  cpu8_pkg::addr_t         redirect_ip,
	output cpu8_pkg::fetch_bundle_t bundle
);
	import cpu8_pkg::*;

	// program memory with no reset
	byte_t rom [rom_depth];

	addr_t ip;
	addr_t ip_plus1;
	byte_t cur_opcode;
	byte_t cur_operand;
	logic  two_byte;
	addr_t next_ip;

	// load port from the testbench
	always_ff @(posedge clk) begin
		if (prog_we && reset) begin
			rom[prog_addr] <= prog_data;
		end
	end

	// opcode and the byte after it
	assign ip_plus1    = ip + addr_t'(1);
	assign cur_opcode  = rom[ip];
	assign cur_operand = rom[ip_plus1];

	// length decode only
	// immediates and branches carry a second byte
	assign two_byte = (cur_opcode[7:6] == cls_imm) || (cur_opcode[7:4] == pfx_branch);
	assign next_ip  = two_byte ? ip + addr_t'(2) : ip_plus1;

	always_ff @(posedge clk) begin
		// payload always follows the ip
		bundle.ip      <= ip;
		bundle.opcode  <= cur_opcode;
		bundle.operand <= cur_operand;
		if (reset) begin
			ip           <= '0;
			bundle.valid <= 1'b0;
		end else if (redirect) begin
			// drop the instruction behind the redirect
			ip           <= redirect_ip;
			bundle.valid <= 1'b0;
		end else begin
			ip           <= next_ip;
			bundle.valid <= 1'b1;
		end
	end

	// program loads belong to reset only
	a_prog_in_reset: assert property (
		@(posedge clk) prog_we |-> reset
	) else $error("prog_we high outside reset");

endmodule

//--- design/cpu8_data_ram.sv
// no reset on the array so contents are undefined until stored; read is asynchronous
`timescale 1ns/1ps

module cpu8_data_ram (
	input  logic            clk,
	input  cpu8_pkg::addr_t rd_addr,
	output cpu8_pkg::byte_t rd_data,
	input  logic            we,
	input  cpu8_pkg::addr_t wr_addr,
	input  cpu8_pkg::byte_t wr_data
);
	import cpu8_pkg::*;

	// data bytes
	byte_t mem [ram_depth];

	// memory operand path into the alu
	// same cycle as the compute
	assign rd_data = mem[rd_addr];

	// stores land at the end of the cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

endmodule

//--- design/cpu8_execute.sv
// one instruction per valid bundle with no stalls; undecoded misc opcodes run as no-ops
`timescale 1ns/1ps

module cpu8_execute (
	input  logic                    clk,
	input  logic                    reset,
	input  cpu8_pkg::fetch_bundle_t bundle,
	output cpu8_pkg::byte_t         alu_a,
	output cpu8_pkg::byte_t         alu_b,
	output logic                    alu_carry,
	output cpu8_pkg::alu_op_e       alu_op,
	input  cpu8_pkg::alu_result_t   alu_y,
	output cpu8_pkg::addr_t         mem_rd_addr,
	input  cpu8_pkg::byte_t         mem_rd_data,
	output logic                    mem_we,
	output cpu8_pkg::addr_t         mem_wr_addr,
	output cpu8_pkg::byte_t         mem_wr_data,
	output logic                    redirect,
	output cpu8_pkg::addr_t         redirect_ip,
	output logic                    store_valid,
	output cpu8_pkg::addr_t         store_addr,
	output cpu8_pkg::byte_t         store_data
);
	import cpu8_pkg::*;

	// architectural state
	byte_t reg_a;
	byte_t reg_b;
	logic  flag_z;
	logic  flag_c;

	// decode
	byte_t opcode;
	byte_t operand;
	dest_e dest;
	byte_t result;
	logic  is_compute;
	logic  is_swap;
	logic  is_clc;
	logic  is_store;
	logic  is_branch;
	logic  is_reset;
	logic  zero_ok;
	logic  carry_ok;
	logic  take_branch;
	logic  jump_ip;

	assign opcode  = bundle.opcode;
	assign operand = bundle.operand;
	assign dest    = dest_e'(opcode[5:4]);
	assign result  = alu_y[byte_w-1:0];

	// every class except 10 is a compute
	assign is_compute = bundle.valid && (opcode[7:6] != cls_misc);
	assign is_swap    = bundle.valid && (opcode == insn_swap_ab);
	assign is_clc     = bundle.valid && (opcode == insn_clear_carry);
	assign is_store   = bundle.valid && (opcode[7:4] == pfx_store);
	assign is_branch  = bundle.valid && (opcode[7:4] == pfx_branch);
	assign is_reset   = bundle.valid && (opcode == insn_reset);

	// a disabled test always passes
	assign zero_ok     = !opcode[brn_zu] || (flag_z == opcode[brn_zv]);
	assign carry_ok    = !opcode[brn_cu] || (flag_c == opcode[brn_cv]);
	assign take_branch = is_branch && zero_ok && carry_ok;
	assign jump_ip     = is_compute && (dest == dest_ip);

	// alu drive
	assign alu_a     = reg_a;
	assign alu_carry = flag_c;
	assign alu_op    = alu_op_e'(opcode[3:0]);

	// second operand by class
	always_comb begin
		unique case (opcode[7:6])
			cls_reg: alu_b = reg_b;
			cls_imm: alu_b = operand;
			cls_mem: alu_b = mem_rd_data;
			default: alu_b = reg_b;
		endcase
	end

	// memory always reads at B
	assign mem_rd_addr = reg_b;
	assign mem_we      = is_store;
	// 4-bit store address zero extended
	assign mem_wr_addr = addr_t'(opcode[3:0]);
	assign mem_wr_data = reg_a;

	// back to fetch
	assign redirect = is_reset || take_branch || jump_ip;
	always_comb begin
		if (is_reset) begin
			redirect_ip = '0;
		end else if (take_branch) begin
			redirect_ip = operand;
		end else begin
			redirect_ip = result;
		end
	end

	// registers and flags
	always_ff @(posedge clk) begin
		if (reset || is_reset) begin
			reg_a  <= '0;
			reg_b  <= '0;
			flag_z <= 1'b0;
			flag_c <= 1'b0;
		end else begin
			if (is_compute) begin
				// flags follow every compute even with no destination
				flag_z <= (result == '0);
				flag_c <= alu_y[byte_w];
				case (dest)
					dest_a:  reg_a <= result;
					dest_b:  reg_b <= result;
					default: ;
				endcase
			end
			if (is_swap) begin
				reg_a <= reg_b;
				reg_b <= reg_a;
			end
			if (is_clc) begin
				flag_c <= 1'b0;
			end
		end
	end

	// store strobe one cycle after the store
	always_ff @(posedge clk) begin
		if (reset) begin
			store_valid <= 1'b0;
		end else begin
			store_valid <= is_store;
		end
	end

	always_ff @(posedge clk) begin
		if (is_store) begin
			store_addr <= mem_wr_addr;
			store_data <= reg_a;
		end
	end

	// a published store never came from a redirecting instruction
	a_store_no_redirect: assert property (
		@(posedge clk) disable iff (reset)
		store_valid |-> !$past(redirect)
	) else $error("store and redirect in one cycle");

	// bubbles leave the state alone
	a_bubble_idle: assert property (
		@(posedge clk) disable iff (reset)
		!bundle.valid |=> $stable({reg_a, reg_b, flag_z, flag_c}) && !store_valid
	) else $error("state changed on an invalid bundle");

endmodule

//--- design/cpu8_top.sv
// program must be loaded through the prog port while reset is high; stores are the only visible output
`timescale 1ns/1ps

module cpu8_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            prog_we,
	input  cpu8_pkg::addr_t prog_addr,
	input  cpu8_pkg::byte_t prog_data,
	output logic            store_valid,
	output cpu8_pkg::addr_t store_addr,
	output cpu8_pkg::byte_t store_data
);
	import cpu8_pkg::*;

	// fetch to execute
	fetch_bundle_t bundle;
	logic          redirect;
	addr_t         redirect_ip;

	// execute to alu
	byte_t         alu_a;
	byte_t         alu_b;
	logic          alu_carry;
	alu_op_e       alu_op;
	alu_result_t   alu_y;

	// execute to data memory
	addr_t         mem_rd_addr;
	byte_t         mem_rd_data;
	logic          mem_we;
	addr_t         mem_wr_addr;
	byte_t         mem_wr_data;

	cpu8_fetch fetch_i (
		.clk         (clk),
		.reset       (reset),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.redirect    (redirect),
		.redirect_ip (redirect_ip),
		.bundle      (bundle)
	);

	cpu8_execute execute_i (
		.clk         (clk),
		.reset       (reset),
		.bundle      (bundle),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_carry   (alu_carry),
		.alu_op      (alu_op),
		.alu_y       (alu_y),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.mem_we      (mem_we),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.redirect    (redirect),
		.redirect_ip (redirect_ip),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	cpu8_alu alu_i (
		.a     (alu_a),
		.b     (alu_b),
		.carry (alu_carry),
		.op    (alu_op),
		.y     (alu_y)
	);

	cpu8_data_ram ram_i (
		.clk     (clk),
		.rd_addr (mem_rd_addr),
		.rd_data (mem_rd_data),
		.we      (mem_we),
		.wr_addr (mem_wr_addr),
		.wr_data (mem_wr_data)
	);

endmodule

//--- verif/cpu8_tb.sv
// programs load while reset is high and end in a jump to self; data memory persists across tests
`timescale 1ns/1ps

module cpu8_tb;
	import cpu8_pkg::*;

	logic  clk = 1'b0;
	logic  reset;
	logic  prog_we;
	addr_t prog_addr;
	byte_t prog_data;
	logic  store_valid;
	addr_t store_addr;
	byte_t store_data;

	// assembler output
	byte_t prog [rom_depth];
	int    plen;
	// model data memory that survives between programs like the DUT's
	byte_t m_mem [ram_depth];
	// expected store strobes in program order
	addr_t exp_addr [$];
	byte_t exp_data [$];
	logic [31:0] lfsr = 32'h4c61da68;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	cpu8_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// limit grows by 64 cycles for every program byte loaded
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// galois lfsr stepped once per bit
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic byte_t rand_byte();
		byte_t v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v = {v[6:0], lfsr_bit()};
		end
		return v;
	endfunction

	// assembler with one function per instruction class
	function automatic void emit(byte_t v);
		prog[addr_t'(plen)] = v;
		plen++;
	endfunction

	function automatic void new_program();
		plen = 0;
	endfunction

	function automatic void compute_reg(dest_e d, alu_op_e op);
		emit({2'b00, d, op});
	endfunction

	function automatic void compute_imm(dest_e d, alu_op_e op, byte_t imm);
		emit({2'b01, d, op});
		emit(imm);
	endfunction

	function automatic void compute_mem(dest_e d, alu_op_e op);
		emit({2'b11, d, op});
	endfunction

	function automatic void swap_ab();
		emit(8'h81);
	endfunction

	function automatic void clear_carry();
		emit(8'h88);
	endfunction

	function automatic void store_a(logic [3:0] addr);
		emit({4'b1001, addr});
	endfunction

	function automatic void branch(logic zv, logic zu, logic cv, logic cu, addr_t target);
		emit({4'b1010, zv, zu, cv, cu});
		emit(target);
	endfunction

	function automatic void reset_insn();
		emit(8'hbf);
	endfunction

	// unconditional branch to its own address
	function automatic void halt();
		branch(1'b0, 1'b0, 1'b0, 1'b0, addr_t'(plen));
	endfunction

	// reference alu giving 9 bits with carry or borrow on top
	function automatic alu_result_t alu_model(alu_op_e op, byte_t a, byte_t b, logic c);
		int x;
		int y;
		int ci;
		int r;
		x = int'(a);
		y = int'(b);
		ci = c ? 1 : 0;
		case (op)
			op_zero:   r = 0;
			op_load_a: r = x;
			op_inc:    r = x + 1;
			op_dec:    r = x - 1;
			op_asl:    r = x * 2;
			op_lsr:    r = x / 2 + (x % 2) * 256;
			op_rol:    r = x * 2 + ci;
			op_ror:    r = x / 2 + ci * 128 + (x % 2) * 256;
			op_or:     r = x | y;
			op_and:    r = x & y;
			op_xor:    r = x ^ y;
			op_load_b: r = y;
			op_add:    r = x + y;
			op_sub:    r = x - y;
			op_adc:    r = x + y + ci;
			default:   r = x - y - ci;
		endcase
		return alu_result_t'(r & 'h1ff);
	endfunction

	// instruction set model that runs until the jump to self
	function automatic void model_run();
		addr_t pc;
		byte_t a;
		byte_t b;
		byte_t op;
		byte_t nb;
		byte_t src;
		logic  z;
		logic  c;
		logic  done;
		alu_result_t r;
		pc = '0;
		a = '0;
		b = '0;
		z = 1'b0;
		c = 1'b0;
		done = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		for (int steps = 0; steps < 4096 && !done; steps++) begin
			op = prog[pc];
			nb = prog[pc + 8'd1];
			if (op[7:6] != 2'b10) begin
				case (op[7:6])
					2'b00:   src = b;
					2'b01:   src = nb;
					default: src = m_mem[b];
				endcase
				r = alu_model(alu_op_e'(op[3:0]), a, src, c);
				z = (r[7:0] == 8'h00);
				c = r[8];
				pc = pc + ((op[7:6] == 2'b01) ? 8'd2 : 8'd1);
				case (op[5:4])
					2'b00:   a = r[7:0];
					2'b01:   b = r[7:0];
					2'b10:   pc = r[7:0];
					default: ;
				endcase
			end else if (op == 8'h81) begin
				src = a;
				a = b;
				b = src;
				pc = pc + 8'd1;
			end else if (op == 8'h88) begin
				c = 1'b0;
				pc = pc + 8'd1;
			end else if (op[7:4] == 4'h9) begin
				m_mem[{4'h0, op[3:0]}] = a;
				exp_addr.push_back({4'h0, op[3:0]});
				exp_data.push_back(a);
				pc = pc + 8'd1;
			end else if (op == 8'hbf) begin
				a = '0;
				b = '0;
				z = 1'b0;
				c = 1'b0;
				pc = '0;
			end else if (op[7:4] == 4'ha) begin
				if (!op[2] && !op[0] && nb == pc) begin
					done = 1'b1;
				end else if ((!op[2] || z == op[3]) && (!op[0] || c == op[1])) begin
					pc = nb;
				end else begin
					pc = pc + 8'd2;
				end
			end else begin
				pc = pc + 8'd1;
			end
		end
	endfunction

	task automatic check_byte(string name, byte_t got, byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// load during reset, release, then match strobes against the model
	task automatic run_program();
		int got;
		int waited;
		model_run();
		cycle_limit += 64 * plen;
		reset = 1'b1;
		for (int i = 0; i < plen || i < 16; i++) begin
			prog_we = (i < plen);
			prog_addr = addr_t'(i);
			prog_data = prog[addr_t'(i)];
			@(negedge clk);
			checks++;
			if (store_valid !== 1'b0) begin
				errors++;
				$display("store strobe seen at %0t while reset is high", $time);
			end
		end
		prog_we = 1'b0;
		reset = 1'b0;
		got = 0;
		waited = 0;
		while (got < exp_data.size() && waited < 48 * plen) begin
			@(negedge clk);
			waited++;
			if (store_valid) begin
				check_addr("store_addr", store_addr, exp_addr[got]);
				check_byte("store_data", store_data, exp_data[got]);
				got++;
			end
		end
		if (got < exp_data.size()) begin
			errors++;
			$display("store %0d of %0d never arrived", got + 1, exp_data.size());
		end
	endtask

	task automatic report(string name, int e0);
		$display("test %s: %0d errors", name, errors - e0);
	endtask

	task automatic test_alu_ops();
		int e0;
		e0 = errors;
		new_program();
		for (int k = 0; k < 16; k++) begin
			compute_imm(dest_a, op_load_b, rand_byte());
			compute_imm(dest_b, op_load_b, rand_byte());
			compute_reg(dest_a, alu_op_e'(k[3:0]));
			store_a(k[3:0]);
		end
		halt();
		run_program();
		report("alu_ops", e0);
	endtask

	task automatic test_carry_chain();
		int e0;
		e0 = errors;
		new_program();
		// 16-bit add where swap keeps the carry for the high byte
		compute_imm(dest_b, op_load_b, rand_byte());
		compute_imm(dest_a, op_load_b, rand_byte() | 8'h80);
		compute_imm(dest_a, op_add, rand_byte() | 8'h80);
		store_a(4'd0);
		swap_ab();
		compute_imm(dest_a, op_adc, rand_byte());
		store_a(4'd1);
		// 16-bit subtract with a forced low borrow
		compute_imm(dest_b, op_load_b, rand_byte());
		compute_imm(dest_a, op_load_b, rand_byte() & 8'h7f);
		compute_imm(dest_a, op_sub, rand_byte() | 8'h80);
		store_a(4'd2);
		swap_ab();
		compute_imm(dest_a, op_sbb, rand_byte());
		store_a(4'd3);
		// rotates through a set carry
		compute_imm(dest_a, op_load_b, rand_byte() | 8'h01);
		compute_imm(dest_nop, op_add, 8'hff);
		compute_reg(dest_a, op_rol);
		store_a(4'd4);
		compute_reg(dest_a, op_ror);
		store_a(4'd5);
		compute_reg(dest_a, op_ror);
		store_a(4'd6);
		// carry set, cleared, then adc of zero
		compute_imm(dest_a, op_load_b, rand_byte() | 8'h01);
		compute_imm(dest_nop, op_add, 8'hff);
		clear_carry();
		compute_imm(dest_a, op_adc, 8'h00);
		store_a(4'd7);
		compute_imm(dest_nop, op_add, 8'hff);
		compute_imm(dest_a, op_adc, 8'h00);
		store_a(4'd8);
		halt();
		run_program();
		report("carry_chain", e0);
	endtask

	// sub and add with dest_nop to reach any z and c pair
	function automatic void set_flags(logic want_z, logic want_c);
		byte_t v;
		v = rand_byte() & 8'h7f;
		if (want_z && want_c) begin
			compute_imm(dest_a, op_load_b, 8'h80);
			compute_imm(dest_nop, op_add, 8'h80);
		end else begin
			compute_imm(dest_a, op_load_b, v | 8'h01);
			if (want_z) begin
				compute_imm(dest_nop, op_sub, v | 8'h01);
			end else if (want_c) begin
				compute_imm(dest_nop, op_sub, v | 8'h81);
			end else begin
				compute_imm(dest_nop, op_sub, v & 8'h7e);
			end
		end
	endfunction

	// fall-through path marks 1x and taken path marks 2x
	function automatic void diamond(logic zv, logic zu, logic cv, logic cu, logic [3:0] addr);
		int p;
		p = plen;
		branch(zv, zu, cv, cu, addr_t'(p + 7));
		compute_imm(dest_a, op_load_b, {4'h1, addr});
		store_a(addr);
		branch(1'b0, 1'b0, 1'b0, 1'b0, addr_t'(p + 10));
		compute_imm(dest_a, op_load_b, {4'h2, addr});
		store_a(addr);
	endfunction

	task automatic test_branches();
		int e0;
		e0 = errors;
		new_program();
		// single tests on z then c with wanted value 1
		for (int k = 0; k < 8; k++) begin
			set_flags(k[0], k[1]);
			diamond(1'b1, !k[2], 1'b1, k[2], k[3:0]);
		end
		// both tests enabled so only z=1 with c=0 is taken
		for (int k = 0; k < 4; k++) begin
			set_flags(k[0], k[1]);
			diamond(1'b1, 1'b1, 1'b0, 1'b1, 4'(k + 8));
		end
		halt();
		run_program();
		report("branches", e0);
	endtask

	task automatic test_mem_swap();
		int e0;
		e0 = errors;
		new_program();
		compute_imm(dest_a, op_load_b, rand_byte());
		store_a(4'd3);
		compute_imm(dest_b, op_load_b, 8'h03);
		compute_imm(dest_a, op_load_b, rand_byte());
		compute_mem(dest_a, op_add);
		store_a(4'd4);
		compute_mem(dest_a, op_xor);
		store_a(4'd5);
		compute_imm(dest_a, op_load_b, rand_byte());
		compute_imm(dest_b, op_load_b, rand_byte());
		swap_ab();
		store_a(4'd6);
		compute_reg(dest_a, op_load_b);
		store_a(4'd7);
		halt();
		run_program();
		report("mem_swap", e0);
	endtask

	task automatic test_jump_reset();
		int e0;
		int p;
		e0 = errors;
		// counter at address 9 starts from zero
		new_program();
		compute_reg(dest_a, op_zero);
		store_a(4'd9);
		halt();
		run_program();
		// each pass bumps the counter until it reaches 3
		new_program();
		store_a(4'd8);
		compute_imm(dest_b, op_load_b, 8'h09);
		compute_mem(dest_a, op_load_b);
		compute_reg(dest_a, op_inc);
		store_a(4'd9);
		compute_imm(dest_nop, op_xor, 8'h03);
		p = plen;
		branch(1'b1, 1'b1, 1'b0, 1'b0, addr_t'(p + 8));
		// jump over a poison store to the reset instruction
		compute_imm(dest_ip, op_load_b, addr_t'(p + 7));
		compute_imm(dest_a, op_load_b, 8'hee);
		store_a(4'd10);
		reset_insn();
		halt();
		run_program();
		report("jump_reset", e0);
	endtask

	task automatic test_store_order();
		int e0;
		e0 = errors;
		new_program();
		compute_imm(dest_a, op_load_b, rand_byte());
		for (int k = 15; k >= 0; k--) begin
			store_a(k[3:0]);
			compute_reg(dest_a, op_inc);
		end
		halt();
		run_program();
		report("store_order", e0);
	endtask

	initial begin
		reset = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		test_alu_ops();
		test_carry_chain();
		test_branches();
		test_mem_swap();
		test_jump_reset();
		test_store_order();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
common/cpu8_pkg.sv
alu/cpu8_alu.sv
design/cpu8_fetch.sv
design/cpu8_data_ram.sv
design/cpu8_execute.sv
design/cpu8_top.sv
verif/cpu8_tb.sv

//--- Makefile
# Verilator build and run of the cpu8 testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu8_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, pass or fail read from $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
